//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // major opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0A;
    localparam logic [5:0] opSltiu   = 6'h0B;
    localparam logic [5:0] opAndi    = 6'h0C;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opXori    = 6'h0E;
    localparam logic [5:0] opLui     = 6'h0F;

    // funct field, only meaningful under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2A;
    localparam logic [5:0] fnSltu = 6'h2B;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluNor, aluSlt, aluSltu, aluLui, aluNop
    } aluOp_e;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_s;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm16;
    } iType_s;

    // same word, two field layouts
    typedef union packed {
        rType_s r;
        iType_s i;
    } instr_u;

    typedef struct packed {
        aluOp_e   aluOp;
        logic     regWrite;
        regAddr_t writeReg; // rd for R-type, rt for I-type
        logic     isImm;    // operand B from the immediate
    } decCtrl_s;

    typedef struct packed {
        word_t    pc;
        decCtrl_s ctrl;
        word_t    opA;
        word_t    opB;
    } execPkt_s;

    typedef struct packed {
        word_t    pc;
        logic     regWrite;
        regAddr_t writeReg;
        word_t    result;
    } wbPkt_s;

    typedef enum logic [1:0] {
        fwdRf,
        fwdEx,
        fwdWb
    } fwdSrc_e;

endpackage

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
    parameter mipsPkg::word_t resetPc = 32'hBFC0_0000
) (
    input  wire            clk,
    input  wire            arstN_i,
    input  wire            stall_i,
    output mipsPkg::word_t pc_o,
    output mipsPkg::word_t fetchPc_o,
    output logic           fetchValid_o
);

    mipsPkg::word_t pcQ;

    // sequential fetch only, no redirects
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcQ          <= resetPc;
            fetchValid_o <= 1'b0;
        end else if (!stall_i) begin
            pcQ          <= pcQ + 32'd4;
            fetchValid_o <= 1'b1; // a request is now in flight
        end
    end

    // address of the word that comes back next cycle
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            fetchPc_o <= pcQ;
        end
    end

    assign pc_o = pcQ;

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    arstN_i,
    input  wire mipsPkg::regAddr_t raddrA_i,
    input  wire mipsPkg::regAddr_t raddrB_i,
    input  wire                    we_i,
    input  wire mipsPkg::regAddr_t waddr_i,
    input  wire mipsPkg::word_t    wdata_i,
    output mipsPkg::word_t         rdataA_o,
    output mipsPkg::word_t         rdataB_o
);

    mipsPkg::word_t regs [1:31]; // $zero has no storage

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];

endmodule

`default_nettype wire

//--- verilog/decodeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
    input  wire                    clk,
    input  wire                    arstN_i,
    input  wire                    stall_i,
    input  wire mipsPkg::word_t    instr_i,
    input  wire mipsPkg::word_t    fetchPc_i,
    input  wire                    fetchValid_i,
    input  wire mipsPkg::word_t    rdataA_i,
    input  wire mipsPkg::word_t    rdataB_i,
    input  wire mipsPkg::decCtrl_s exCtrl_i,
    input  wire                    exValid_i,
    input  wire mipsPkg::word_t    exResult_i,
    input  wire mipsPkg::wbPkt_s   wb_i,
    input  wire                    wbValid_i,
    output mipsPkg::regAddr_t      raddrA_o,
    output mipsPkg::regAddr_t      raddrB_o,
    output mipsPkg::execPkt_s      ex_o,
    output logic                   exValid_o
);

    mipsPkg::instr_u   instrD;
    mipsPkg::word_t    pcD;
    logic              validD;
    mipsPkg::decCtrl_s ctrl;
    logic              zeroExt;
    mipsPkg::word_t    imm;
    mipsPkg::fwdSrc_e  fwdA;
    mipsPkg::fwdSrc_e  fwdB;
    mipsPkg::word_t    srcA;
    mipsPkg::word_t    srcB;

    // youngest producer wins, $zero never forwarded
    function automatic mipsPkg::fwdSrc_e fwdSel(input mipsPkg::regAddr_t src);
        if (src == '0) begin
            return mipsPkg::fwdRf;
        end
        if (exValid_i && exCtrl_i.regWrite && exCtrl_i.writeReg == src) begin
            return mipsPkg::fwdEx;
        end
        if (wbValid_i && wb_i.regWrite && wb_i.writeReg == src) begin
            return mipsPkg::fwdWb;
        end
        return mipsPkg::fwdRf;
    endfunction

    function automatic mipsPkg::word_t fwdMux(input mipsPkg::fwdSrc_e sel,
                                              input mipsPkg::word_t rf);
        case (sel)
            mipsPkg::fwdEx: return exResult_i;
            mipsPkg::fwdWb: return wb_i.result;
            default:        return rf;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            validD <= 1'b0;
        end else if (!stall_i) begin
            validD <= fetchValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            instrD <= instr_i;
            pcD    <= fetchPc_i;
        end
    end

    always_comb begin
        ctrl.aluOp    = mipsPkg::aluNop;
        ctrl.writeReg = instrD.i.rt;
        ctrl.isImm    = 1'b1;
        zeroExt       = 1'b0;
        case (instrD.i.opcode)
            mipsPkg::opSpecial: begin
                ctrl.writeReg = instrD.r.rd;
                ctrl.isImm    = 1'b0;
                case (instrD.r.funct)
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnNor:  ctrl.aluOp = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
                    default:         ctrl.aluOp = mipsPkg::aluNop;
                endcase
            end
            mipsPkg::opAddiu: ctrl.aluOp = mipsPkg::aluAdd;
            mipsPkg::opSlti:  ctrl.aluOp = mipsPkg::aluSlt;
            mipsPkg::opSltiu: ctrl.aluOp = mipsPkg::aluSltu;
            mipsPkg::opLui:   ctrl.aluOp = mipsPkg::aluLui;
            mipsPkg::opAndi: begin
                ctrl.aluOp = mipsPkg::aluAnd;
                zeroExt    = 1'b1;
            end
            mipsPkg::opOri: begin
                ctrl.aluOp = mipsPkg::aluOr;
                zeroExt    = 1'b1;
            end
            mipsPkg::opXori: begin
                ctrl.aluOp = mipsPkg::aluXor;
                zeroExt    = 1'b1;
            end
            default: ctrl.aluOp = mipsPkg::aluNop;
        endcase
        ctrl.regWrite = (ctrl.aluOp != mipsPkg::aluNop); // unknown words retire silently
    end

    assign imm = zeroExt ? {16'b0, instrD.i.imm16} : {{16{instrD.i.imm16[15]}}, instrD.i.imm16};

    assign raddrA_o = instrD.r.rs;
    assign raddrB_o = instrD.r.rt;

    always_comb begin
        fwdA = fwdSel(instrD.r.rs);
        fwdB = fwdSel(instrD.r.rt);
        srcA = fwdMux(fwdA, rdataA_i);
        srcB = fwdMux(fwdB, rdataB_i);
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            exValid_o <= 1'b0;
        end else if (!stall_i) begin
            exValid_o <= validD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_o.pc   <= pcD;
            ex_o.ctrl <= ctrl;
            ex_o.opA  <= srcA;
            ex_o.opB  <= ctrl.isImm ? imm : srcB; // lui also takes imm here
        end
    end

endmodule

`default_nettype wire

//--- verilog/execUnit.sv
`timescale 1ns/100ps
`default_nettype none

module execUnit (
    input  wire                    clk,
    input  wire                    arstN_i,
    input  wire                    stall_i,
    input  wire mipsPkg::execPkt_s ex_i,
    input  wire                    exValid_i,
    output mipsPkg::word_t         exResult_o,
    output mipsPkg::wbPkt_s        wb_o,
    output logic                   wbValid_o
);

    mipsPkg::word_t aluOut;
    logic           writes;

    always_comb begin
        case (ex_i.ctrl.aluOp)
            mipsPkg::aluAdd:  aluOut = ex_i.opA + ex_i.opB;
            mipsPkg::aluSub:  aluOut = ex_i.opA - ex_i.opB;
            mipsPkg::aluAnd:  aluOut = ex_i.opA & ex_i.opB;
            mipsPkg::aluOr:   aluOut = ex_i.opA | ex_i.opB;
            mipsPkg::aluXor:  aluOut = ex_i.opA ^ ex_i.opB;
            mipsPkg::aluNor:  aluOut = ~(ex_i.opA | ex_i.opB);
            mipsPkg::aluSlt:  aluOut = mipsPkg::word_t'($signed(ex_i.opA) < $signed(ex_i.opB));
            mipsPkg::aluSltu: aluOut = mipsPkg::word_t'(ex_i.opA < ex_i.opB);
            mipsPkg::aluLui:  aluOut = ex_i.opB << 16;
            default:          aluOut = '0;
        endcase
    end

    assign exResult_o = aluOut; // forwarded back to decode

    // writes to $zero and unknown ops never reach the register file
    assign writes = ex_i.ctrl.regWrite
                    && ex_i.ctrl.aluOp != mipsPkg::aluNop
                    && ex_i.ctrl.writeReg != '0;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            wbValid_o <= 1'b0;
        end else if (!stall_i) begin
            wbValid_o <= exValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_o.pc       <= ex_i.pc;
            wb_o.regWrite <= writes;
            wb_o.writeReg <= ex_i.ctrl.writeReg;
            wb_o.result   <= aluOut;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
    parameter mipsPkg::word_t resetPc = 32'hBFC0_0000
) (
    input  wire                 clk,
    input  wire                 arstN_i,
    input  wire mipsPkg::word_t instr_i,
    input  wire                 imemStall_i,
    output mipsPkg::word_t      pcIf_o,
    output logic                instEn_o,
    output mipsPkg::word_t      debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output mipsPkg::regAddr_t   debug_wb_rf_wnum_o,
    output mipsPkg::word_t      debug_wb_rf_wdata_o
);

    mipsPkg::word_t    fetchPc;
    logic              fetchValid;
    mipsPkg::regAddr_t raddrA;
    mipsPkg::regAddr_t raddrB;
    mipsPkg::word_t    rdataA;
    mipsPkg::word_t    rdataB;
    mipsPkg::execPkt_s exPkt;
    logic              exValid;
    mipsPkg::word_t    exResult;
    mipsPkg::wbPkt_s   wbPkt;
    logic              wbValid;
    logic              rfWe;

    // first fetch goes out in the cycle reset is released
    assign instEn_o = arstN_i;

    fetchUnit #(.resetPc(resetPc)) fetch (
        .clk(clk), .arstN_i(arstN_i), .stall_i(imemStall_i),
        .pc_o(pcIf_o), .fetchPc_o(fetchPc), .fetchValid_o(fetchValid)
    );

    decodeUnit decode (
        .clk(clk), .arstN_i(arstN_i), .stall_i(imemStall_i),
        .instr_i(instr_i), .fetchPc_i(fetchPc), .fetchValid_i(fetchValid),
        .rdataA_i(rdataA), .rdataB_i(rdataB),
        .exCtrl_i(exPkt.ctrl), .exValid_i(exValid), .exResult_i(exResult),
        .wb_i(wbPkt), .wbValid_i(wbValid),
        .raddrA_o(raddrA), .raddrB_o(raddrB), .ex_o(exPkt), .exValid_o(exValid)
    );

    regFile rf (
        .clk(clk), .arstN_i(arstN_i), .raddrA_i(raddrA), .raddrB_i(raddrB),
        .we_i(rfWe), .waddr_i(wbPkt.writeReg), .wdata_i(wbPkt.result),
        .rdataA_o(rdataA), .rdataB_o(rdataB)
    );

    execUnit exec (
        .clk(clk), .arstN_i(arstN_i), .stall_i(imemStall_i),
        .ex_i(exPkt), .exValid_i(exValid),
        .exResult_o(exResult), .wb_o(wbPkt), .wbValid_o(wbValid)
    );

    // retire only on a cycle the pipeline actually moves
    assign rfWe = wbValid & wbPkt.regWrite & ~imemStall_i;

    assign debug_wb_pc_o       = wbPkt.pc;
    assign debug_wb_rf_wen_o   = {4{rfWe}};
    assign debug_wb_rf_wnum_o  = wbPkt.writeReg;
    assign debug_wb_rf_wdata_o = wbPkt.result;

endmodule

`default_nettype wire

//--- tests/coreTb.sv
`timescale 1ns/100ps
`default_nettype none

module coreTb;

    localparam mipsPkg::word_t resetPc = 32'hBFC0_0000;

    // one program word plus the retire it should produce
    typedef struct packed {
        mipsPkg::word_t    instr;
        logic              wen;
        mipsPkg::regAddr_t wnum;
        mipsPkg::word_t    wdata;
    } progRow_s;

    logic              clk;
    logic              arstN;
    mipsPkg::word_t    instr;
    logic              imemStall;
    mipsPkg::word_t    pcIf;
    logic              instEn;
    mipsPkg::word_t    dbgPc;
    logic [3:0]        dbgWen;
    mipsPkg::regAddr_t dbgWnum;
    mipsPkg::word_t    dbgWdata;

    progRow_s       prog[$];
    int             seed;
    int             resetCycles;
    logic           moved;   // last cycle accepted a fetch
    mipsPkg::word_t lastPc;
    mipsPkg::word_t reqAddr; // address whose word the memory returns
    int             errs;
    int             passed;
    int             failed;

    mipsCore #(.resetPc(resetPc)) dut (
        .clk(clk), .arstN_i(arstN), .instr_i(instr), .imemStall_i(imemStall),
        .pcIf_o(pcIf), .instEn_o(instEn),
        .debug_wb_pc_o(dbgPc), .debug_wb_rf_wen_o(dbgWen),
        .debug_wb_rf_wnum_o(dbgWnum), .debug_wb_rf_wdata_o(dbgWdata)
    );

    always #10 clk = ~clk;

    function automatic mipsPkg::word_t encR(input logic [5:0] funct, input int rs,
                                            input int rt, input int rd);
        mipsPkg::instr_u w;
        w.r.opcode = mipsPkg::opSpecial;
        w.r.rs     = rs[4:0];
        w.r.rt     = rt[4:0];
        w.r.rd     = rd[4:0];
        w.r.shamt  = 5'd0;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic mipsPkg::word_t encI(input logic [5:0] op, input int rs,
                                            input int rt, input logic [15:0] imm);
        mipsPkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs[4:0];
        w.i.rt     = rt[4:0];
        w.i.imm16  = imm;
        return w;
    endfunction

    task automatic addRow(input mipsPkg::word_t w, input logic wen,
                          input mipsPkg::regAddr_t wnum, input mipsPkg::word_t wdata);
        progRow_s row;
        row.instr = w;
        row.wen   = wen;
        row.wnum  = wnum;
        row.wdata = wdata;
        prog.push_back(row);
    endtask

    // past the table the memory reads zero, a no-op
    function automatic mipsPkg::word_t fetchWord(input mipsPkg::word_t addr);
        mipsPkg::word_t idx;
        idx = (addr - resetPc) >> 2;
        if (idx < prog.size()) begin
            return prog[idx].instr;
        end
        return '0;
    endfunction

    task automatic checkWord(input mipsPkg::word_t got, input mipsPkg::word_t exp,
                             input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic checkReg(input mipsPkg::regAddr_t got, input mipsPkg::regAddr_t exp,
                            input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic checkBit(input logic [3:0] got, input logic exp, input string what);
        if (got !== {4{exp}}) begin
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, {4{exp}});
            errs++;
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic endTest(input string name, input int errsBefore);
        if (errs == errsBefore) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: failed", name);
            failed++;
        end
    endtask

    // instruction memory and stall source, just after the rising edge
    always @(posedge clk) begin
        #2;
        if (!arstN) begin
            resetCycles++;
            if (resetCycles == 4) begin
                arstN = 1'b1;
            end
        end
        if (arstN) begin
            if (moved) begin
                reqAddr = lastPc;
            end
            instr     = fetchWord(reqAddr);
            imemStall = !imemStall && (($random(seed) & 3) == 0); // never twice running
            lastPc    = pcIf;
            moved     = !imemStall;
        end
    end

    initial begin
        int       rowIdx;
        int       moves;
        int       cycles;
        int       limit;
        int       errsAtStart;
        progRow_s row;
        clk         = 1'b0;
        arstN       = 1'b0;
        instr       = '0;
        imemStall   = 1'b0;
        seed        = 54681;
        resetCycles = 0;
        moved       = 1'b0;
        lastPc      = resetPc;
        reqAddr     = resetPc;
        errs        = 0;
        passed      = 0;
        failed      = 0;

        // seed registers
        addRow(encI(mipsPkg::opLui, 0, 1, 16'h8000), 1'b1, 5'd1, 32'h8000_0000);
        addRow(encI(mipsPkg::opOri, 1, 1, 16'h0005), 1'b1, 5'd1, 32'h8000_0005);
        addRow(encI(mipsPkg::opOri, 0, 2, 16'h1234), 1'b1, 5'd2, 32'h0000_1234);
        addRow(encI(mipsPkg::opOri, 0, 3, 16'h00F0), 1'b1, 5'd3, 32'h0000_00F0);
        // r-type ops, r1 is negative as signed
        addRow(encR(mipsPkg::fnAddu, 1, 2, 4), 1'b1, 5'd4, 32'h8000_1239);
        addRow(encR(mipsPkg::fnSubu, 2, 3, 5), 1'b1, 5'd5, 32'h0000_1144);
        addRow(encR(mipsPkg::fnAnd, 1, 2, 6), 1'b1, 5'd6, 32'h0000_0004);
        addRow(encR(mipsPkg::fnOr, 1, 3, 7), 1'b1, 5'd7, 32'h8000_00F5);
        addRow(encR(mipsPkg::fnXor, 2, 3, 8), 1'b1, 5'd8, 32'h0000_12C4);
        addRow(encR(mipsPkg::fnNor, 2, 3, 9), 1'b1, 5'd9, 32'hFFFF_ED0B);
        addRow(encR(mipsPkg::fnSlt, 1, 2, 10), 1'b1, 5'd10, 32'd1);
        addRow(encR(mipsPkg::fnSltu, 1, 2, 11), 1'b1, 5'd11, 32'd0);
        // immediates, sign vs zero extension
        addRow(encI(mipsPkg::opAddiu, 2, 12, 16'hFFFC), 1'b1, 5'd12, 32'h0000_1230);
        addRow(encI(mipsPkg::opSlti, 1, 13, 16'hFFFF), 1'b1, 5'd13, 32'd1);
        addRow(encI(mipsPkg::opSltiu, 2, 14, 16'hFFFF), 1'b1, 5'd14, 32'd1);
        addRow(encI(mipsPkg::opAndi, 1, 15, 16'h8005), 1'b1, 5'd15, 32'h0000_0005);
        addRow(encI(mipsPkg::opOri, 0, 16, 16'h8000), 1'b1, 5'd16, 32'h0000_8000);
        addRow(encI(mipsPkg::opXori, 9, 17, 16'hF00F), 1'b1, 5'd17, 32'hFFFF_1D04);
        addRow(encI(mipsPkg::opLui, 0, 18, 16'hABCD), 1'b1, 5'd18, 32'hABCD_0000);
        // dependency chain one, two and three back
        addRow(encI(mipsPkg::opAddiu, 0, 19, 16'h0007), 1'b1, 5'd19, 32'd7);
        addRow(encR(mipsPkg::fnAddu, 19, 19, 20), 1'b1, 5'd20, 32'd14);
        addRow(encR(mipsPkg::fnAddu, 20, 19, 21), 1'b1, 5'd21, 32'd21);
        addRow(encR(mipsPkg::fnSubu, 21, 19, 22), 1'b1, 5'd22, 32'd14);
        // $zero target, then a read of $zero
        addRow(encI(mipsPkg::opOri, 19, 0, 16'h00FF), 1'b0, 5'd0, 32'd0);
        addRow(encR(mipsPkg::fnAddu, 0, 20, 23), 1'b1, 5'd23, 32'd14);
        addRow(32'hFC00_0000, 1'b0, 5'd0, 32'd0); // undefined opcode
        addRow(encR(mipsPkg::fnSubu, 22, 21, 24), 1'b1, 5'd24, 32'hFFFF_FFF9);
        addRow(encI(mipsPkg::opAddiu, 24, 24, 16'h0001), 1'b1, 5'd24, 32'hFFFF_FFFA);
        addRow(encR(6'h20, 24, 19, 25), 1'b0, 5'd0, 32'd0); // funct not decoded
        addRow(encR(mipsPkg::fnSltu, 24, 19, 25), 1'b1, 5'd25, 32'd0);
        addRow(encR(mipsPkg::fnSlt, 24, 19, 26), 1'b1, 5'd26, 32'd1);
        limit = 2 * prog.size() + 40;

        errsAtStart = errs;
        @(negedge clk);
        while (!arstN) begin
            checkWord(pcIf, resetPc, "pc during reset");
            checkBit(dbgWen, 1'b0, "wen during reset");
            checkFlag(instEn, 1'b0, "instEn during reset");
            @(negedge clk);
        end
        checkWord(pcIf, resetPc, "pc after reset"); // no edge since release yet
        checkBit(dbgWen, 1'b0, "wen after reset");
        checkFlag(instEn, 1'b1, "instEn after reset");
        endTest("reset", errsAtStart);

        // row k retires in the (k+4)th moving cycle counted from release
        rowIdx      = 0;
        moves       = 0;
        cycles      = 0;
        errsAtStart = errs;
        while (rowIdx < prog.size() && cycles < limit) begin
            checkFlag(instEn, 1'b1, "instEn out of reset");
            if (imemStall) begin
                checkBit(dbgWen, 1'b0, "wen in stall cycle");
            end else begin
                if (moves >= 4) begin
                    row = prog[rowIdx];
                    checkWord(dbgPc, resetPc + mipsPkg::word_t'(4 * rowIdx),
                              $sformatf("row %0d pc", rowIdx));
                    checkBit(dbgWen, row.wen, $sformatf("row %0d wen", rowIdx));
                    if (row.wen) begin
                        checkReg(dbgWnum, row.wnum, $sformatf("row %0d wnum", rowIdx));
                        checkWord(dbgWdata, row.wdata, $sformatf("row %0d wdata", rowIdx));
                    end
                    endTest($sformatf("row %0d", rowIdx), errsAtStart);
                    errsAtStart = errs;
                    rowIdx++;
                end else begin
                    checkBit(dbgWen, 1'b0, "wen before first retire");
                end
                moves++;
            end
            @(negedge clk);
            cycles++;
        end

        if (rowIdx < prog.size()) begin
            $display("timeout: not every instruction retired");
            failed++;
        end
        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/mipsPkg.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/execUnit.sv
verilog/mipsCore.sv
tests/coreTb.sv

//--- Bender.yml
package:
  name: mips_core

dependencies: {}

sources:
  # rtl, package first
  - files:
      - verilog/mipsPkg.sv
      - verilog/fetchUnit.sv
      - verilog/regFile.sv
      - verilog/decodeUnit.sv
      - verilog/execUnit.sv
      - verilog/mipsCore.sv

  # testbench
  - target: simulation
    files:
      - tests/coreTb.sv
